/* hw/dm_params.svh */
/*
 * Debug module configuration
 * sizes, DMI register map and the implicit ebreak word
 */
`ifndef DM_PARAMS_SVH
`define DM_PARAMS_SVH

`define DM_NUM_HARTS        4
`define DM_PROG_SIZE        4                   // program buffer words
`define DM_DATA_SIZE        2                   // data buffer words
`define DM_BUF_WORDS        (`DM_PROG_SIZE + `DM_DATA_SIZE)
`define DM_BUF_IDX_W        ($clog2(`DM_BUF_WORDS))
`define DM_HARTSEL_W        20
`define DM_DMI_ADDR_W       7
`define DM_DMI_DATA_W       32
`define DM_SRI_ADDR_W       6                   // byte address, word index in [5:2]
`define DM_EBREAK           32'h00100073

// DMI register addresses
`define DM_ADDR_DATA0       7'h04
`define DM_ADDR_DMCONTROL   7'h10
`define DM_ADDR_DMSTATUS    7'h11
`define DM_ADDR_ABSTRACTCS  7'h16
`define DM_ADDR_PROGBUF0    7'h20
`define DM_ADDR_SBCS        7'h38

`endif

/* hw/dm_pkg.sv */
/*
 * Debug module types
 * DMI opcodes and response codes, front-end states
 * and the dmstatus register layout
 */
`include "dm_params.svh"

package dm_pkg;

    typedef enum logic [1:0] {
        DMI_NOP   = 2'd0,
        DMI_READ  = 2'd1,
        DMI_WRITE = 2'd2
    } dmi_op_e;

    typedef enum logic [1:0] {
        DMI_OK    = 2'd0,
        DMI_ERROR = 2'd2
    } dmi_resp_e;

    typedef enum logic {
        IDLE,
        RESP
    } dm_state_e;

    // msb first
    typedef struct packed {
        logic [11:0] zero2;
        logic        allhavereset;      // 19
        logic        anyhavereset;
        logic        allresumeack;
        logic        anyresumeack;      // 16
        logic [1:0]  zero1;             // nonexistent, never reported
        logic        allunavail;        // 13
        logic        anyunavail;
        logic        allrunning;
        logic        anyrunning;
        logic        allhalted;
        logic        anyhalted;         // 8
        logic        authenticated;     // 7
        logic [2:0]  zero0;
        logic [3:0]  version;
    } dmstatus_t;

endpackage

/* hw/dm_dmi_frontend.sv */
/*
 * DMI front end
 * one request at a time, response one cycle after accept,
 * decodes the register map, keeps hartsel and dmactive and
 * strobes dmcontrol and buffer writes in the first response cycle
 */
`timescale 1ns/100ps
`include "dm_params.svh"

module dm_dmi_frontend (
    input  logic                          clk_i,
    input  logic                          rstn_i,
    input  logic                          req_valid_i,
    input  logic [`DM_DMI_ADDR_W-1:0]     req_addr_i,
    input  logic [`DM_DMI_DATA_W-1:0]     req_data_i,
    input  dm_pkg::dmi_op_e               req_op_i,
    input  logic                          resp_ready_i,
    input  dm_pkg::dmstatus_t             dmstatus_i,
    input  logic [`DM_DMI_DATA_W-1:0]     buf_rdata_i,
    output logic                          req_ready_o,
    output logic                          resp_valid_o,
    output logic [`DM_DMI_DATA_W-1:0]     resp_data_o,
    output dm_pkg::dmi_resp_e             resp_op_o,
    output logic                          ctrl_we_o,
    output logic [`DM_NUM_HARTS-1:0]      hart_sel_o,
    output logic                          haltreq_o,
    output logic                          resumereq_o,
    output logic                          ackhavereset_o,
    output logic [`DM_HARTSEL_W-1:0]      hartsel_o,
    output logic                          buf_we_o,
    output logic [`DM_BUF_IDX_W-1:0]      buf_idx_o,
    output logic [`DM_DMI_DATA_W-1:0]     buf_wdata_o
);
    localparam int IDX_W = `DM_BUF_IDX_W;

    dm_pkg::dm_state_e           state_q;
    logic                        first_q;       // first cycle of RESP
    logic [`DM_DMI_ADDR_W-1:0]   addr_q;
    logic [`DM_DMI_DATA_W-1:0]   data_q;
    dm_pkg::dmi_op_e             op_q;
    logic [`DM_DMI_DATA_W-1:0]   resp_data_q;
    logic [`DM_DMI_DATA_W-1:0]   rdata;
    logic [`DM_HARTSEL_W-1:0]    hartsel_q;
    logic [`DM_HARTSEL_W-1:0]    hartsel_wr;
    logic [`DM_HARTSEL_W-1:0]    hartsel_new;
    logic                        dmactive_q;
    logic                        is_prog;
    logic                        is_data;
    logic                        wr_strobe;

    assign req_ready_o  = (state_q == dm_pkg::IDLE);
    assign resp_valid_o = (state_q == dm_pkg::RESP);
    assign wr_strobe    = first_q && (op_q == dm_pkg::DMI_WRITE);

    assign is_prog = (addr_q >= `DM_ADDR_PROGBUF0) &&
                     (addr_q < `DM_ADDR_PROGBUF0 + `DM_PROG_SIZE);
    assign is_data = (addr_q >= `DM_ADDR_DATA0) &&
                     (addr_q < `DM_ADDR_DATA0 + `DM_DATA_SIZE);

    // dmcontrol fields of the latched request
    assign hartsel_wr     = {data_q[15:6], data_q[25:16]};   // {hartselhi, hartsello}
    assign hartsel_new    = (hartsel_wr < `DM_NUM_HARTS) ? hartsel_wr : hartsel_q;
    assign ctrl_we_o      = wr_strobe && (addr_q == `DM_ADDR_DMCONTROL);
    assign haltreq_o      = data_q[31];
    assign resumereq_o    = data_q[30];
    assign ackhavereset_o = data_q[28];
    assign hartsel_o      = hartsel_q;

    always_comb begin
        for (int i = 0; i < `DM_NUM_HARTS; i++) begin
            hart_sel_o[i] = (hartsel_new == i);
        end
    end

    // data k sits behind the program words
    assign buf_we_o    = wr_strobe && (is_prog || is_data);
    assign buf_idx_o   = is_prog ? IDX_W'(addr_q - `DM_ADDR_PROGBUF0)
                                 : IDX_W'(addr_q - `DM_ADDR_DATA0 + `DM_PROG_SIZE);
    assign buf_wdata_o = data_q;

    always_comb begin
        rdata = '0;
        if (op_q == dm_pkg::DMI_READ) begin
            if (is_prog || is_data) begin
                rdata = buf_rdata_i;
            end else begin
                case (addr_q)
                    `DM_ADDR_DMCONTROL: begin
                        rdata[25:16] = hartsel_q[9:0];
                        rdata[0]     = dmactive_q;
                    end
                    `DM_ADDR_DMSTATUS:   rdata = dmstatus_i;
                    `DM_ADDR_ABSTRACTCS: begin
                        rdata[28:24] = 5'(`DM_PROG_SIZE);  // progbufsize
                        rdata[3:0]   = 4'(`DM_DATA_SIZE);  // datacount
                    end
                    default: ;
                endcase
            end
        end
    end

    // held after the first cycle so back-pressure sees a stable word
    assign resp_data_o = first_q ? rdata : resp_data_q;
    assign resp_op_o   = (op_q == dm_pkg::DMI_WRITE && addr_q == `DM_ADDR_SBCS) ?
                         dm_pkg::DMI_ERROR : dm_pkg::DMI_OK;

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            state_q    <= dm_pkg::IDLE;
            first_q    <= 1'b0;
            hartsel_q  <= '0;
            dmactive_q <= 1'b0;
        end else begin
            first_q <= 1'b0;
            case (state_q)
                dm_pkg::IDLE: if (req_valid_i) begin
                    state_q <= dm_pkg::RESP;
                    first_q <= 1'b1;
                end
                dm_pkg::RESP: if (resp_ready_i) state_q <= dm_pkg::IDLE;
                default: state_q <= dm_pkg::IDLE;
            endcase
            if (ctrl_we_o) begin
                hartsel_q  <= hartsel_new;
                dmactive_q <= data_q[0];
            end
        end
    end

    // request payload
    always_ff @(posedge clk_i) begin
        if (req_valid_i && req_ready_o) begin
            addr_q <= req_addr_i;
            data_q <= req_data_i;
            op_q   <= req_op_i;
        end
        if (first_q) resp_data_q <= rdata;
    end

endmodule

/* hw/dm_hart_ctrl.sv */
/*
 * Per-hart run control
 * halt and resume request levels set by dmcontrol writes
 * and the sticky havereset flag
 */
`timescale 1ns/100ps
`include "dm_params.svh"

module dm_hart_ctrl (
    input  logic clk_i,
    input  logic rstn_i,
    input  logic ctrl_we_i,         // dmcontrol write strobe
    input  logic sel_i,             // this hart is the selected one
    input  logic haltreq_i,
    input  logic resumereq_i,
    input  logic ackhavereset_i,
    input  logic havereset_i,       // from the hart
    output logic halt_request_o,
    output logic resume_request_o,
    output logic havereset_o
);
    logic we;
    logic halt_q;
    logic resume_q;
    logic havereset_q;

    assign we = ctrl_we_i && sel_i;

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            halt_q      <= 1'b0;
            resume_q    <= 1'b0;
            havereset_q <= 1'b0;
        end else begin
            if (we) begin
                halt_q <= haltreq_i;
                // a pending or new halt blocks resume
                if (!(halt_q || haltreq_i)) resume_q <= resumereq_i;
            end
            if (we && ackhavereset_i) havereset_q <= 1'b0;   // ack beats a new reset
            else if (havereset_i) havereset_q <= 1'b1;
        end
    end

    assign halt_request_o   = halt_q;
    assign resume_request_o = resume_q;
    assign havereset_o      = havereset_q;

endmodule

/* hw/dm_status_collect.sv */
/*
 * dmstatus builder
 * the window is the selected hart alone, so each any/all
 * pair reports that hart's status bit
 */
`timescale 1ns/100ps
`include "dm_params.svh"

module dm_status_collect (
    input  logic [`DM_HARTSEL_W-1:0]  hartsel_i,
    input  logic [`DM_NUM_HARTS-1:0]  halted_i,
    input  logic [`DM_NUM_HARTS-1:0]  running_i,
    input  logic [`DM_NUM_HARTS-1:0]  unavail_i,
    input  logic [`DM_NUM_HARTS-1:0]  resume_ack_i,
    input  logic [`DM_NUM_HARTS-1:0]  havereset_i,
    output dm_pkg::dmstatus_t         dmstatus_o
);
    logic [`DM_NUM_HARTS-1:0] sel_mask;

    always_comb begin
        for (int i = 0; i < `DM_NUM_HARTS; i++) begin
            sel_mask[i] = (hartsel_i == i);
        end
    end

    always_comb begin
        dmstatus_o               = '0;
        dmstatus_o.version       = 4'd3;    // spec 1.0
        dmstatus_o.authenticated = 1'b1;
        dmstatus_o.anyhalted     = |(halted_i & sel_mask);
        dmstatus_o.allhalted     = |(halted_i & sel_mask);
        dmstatus_o.anyrunning    = |(running_i & sel_mask);
        dmstatus_o.allrunning    = |(running_i & sel_mask);
        dmstatus_o.anyunavail    = |(unavail_i & sel_mask);
        dmstatus_o.allunavail    = |(unavail_i & sel_mask);
        dmstatus_o.anyresumeack  = |(resume_ack_i & sel_mask);
        dmstatus_o.allresumeack  = |(resume_ack_i & sel_mask);
        dmstatus_o.anyhavereset  = |(havereset_i & sel_mask);
        dmstatus_o.allhavereset  = |(havereset_i & sel_mask);
    end

endmodule

/* hw/dm_progbuf_mem.sv */
/*
 * Program and data buffer
 * 32-bit word port for DMI, 64-bit byte-enabled port for the core
 * words past the end read back as ebreak
 */
`timescale 1ns/100ps
`include "dm_params.svh"

module dm_progbuf_mem (
    input  logic                          clk_i,
    input  logic                          rstn_i,
    input  logic                          dmi_we_i,
    input  logic [`DM_BUF_IDX_W-1:0]      dmi_idx_i,
    input  logic [`DM_DMI_DATA_W-1:0]     dmi_wdata_i,
    input  logic                          sri_en_i,
    input  logic                          sri_we_i,
    input  logic [`DM_SRI_ADDR_W-1:0]     sri_addr_i,
    input  logic [63:0]                   sri_wdata_i,
    input  logic [7:0]                    sri_be_i,
    output logic [`DM_DMI_DATA_W-1:0]     dmi_rdata_o,
    output logic [63:0]                   sri_rdata_o,
    output logic                          sri_error_o
);
    localparam int WORDS = `DM_BUF_WORDS;
    localparam int IDX_W = `DM_BUF_IDX_W;

    logic [31:0]                 mem_q [WORDS];
    logic [`DM_SRI_ADDR_W-2:0]   lo_idx;     // one spare bit for w+1
    logic [`DM_SRI_ADDR_W-2:0]   hi_idx;
    logic                        lo_ok;
    logic                        hi_ok;
    logic                        sri_wr;

    assign lo_idx = {1'b0, sri_addr_i[`DM_SRI_ADDR_W-1:2]};
    assign hi_idx = lo_idx + 1'b1;
    assign lo_ok  = (lo_idx < WORDS);
    assign hi_ok  = (hi_idx < WORDS);
    assign sri_wr = sri_en_i && sri_we_i;

    assign dmi_rdata_o = mem_q[dmi_idx_i];

    // implicit ebreak past the last data word
    assign sri_rdata_o[31:0]  = lo_ok ? mem_q[lo_idx[IDX_W-1:0]] : `DM_EBREAK;
    assign sri_rdata_o[63:32] = hi_ok ? mem_q[hi_idx[IDX_W-1:0]] : `DM_EBREAK;

    assign sri_error_o = sri_wr && !lo_ok;

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            for (int i = 0; i < WORDS; i++) begin
                mem_q[i] <= '0;
            end
        end else if (dmi_we_i) begin
            mem_q[dmi_idx_i] <= dmi_wdata_i;   // debugger has priority
        end else if (sri_wr) begin
            for (int b = 0; b < 4; b++) begin
                if (lo_ok && sri_be_i[b]) begin
                    mem_q[lo_idx[IDX_W-1:0]][8*b +: 8] <= sri_wdata_i[8*b +: 8];
                end
                if (hi_ok && sri_be_i[b+4]) begin
                    mem_q[hi_idx[IDX_W-1:0]][8*b +: 8] <= sri_wdata_i[32+8*b +: 8];
                end
            end
        end
    end

endmodule

/* hw/riscv_dm_top.sv */
/*
 * Reduced RISC-V debug module
 * DMI front end, one run-control block per hart,
 * dmstatus collector and the program/data buffer
 */
`timescale 1ns/100ps
`include "dm_params.svh"

module riscv_dm_top (
    input  logic                          clk_i,
    input  logic                          rstn_i,
    // DMI
    input  logic                          req_valid_i,
    output logic                          req_ready_o,
    input  logic [`DM_DMI_ADDR_W-1:0]     req_addr_i,
    input  logic [`DM_DMI_DATA_W-1:0]     req_data_i,
    input  dm_pkg::dmi_op_e               req_op_i,
    output logic                          resp_valid_o,
    input  logic                          resp_ready_i,
    output logic [`DM_DMI_DATA_W-1:0]     resp_data_o,
    output dm_pkg::dmi_resp_e             resp_op_o,
    // SRI, core side of the buffer
    input  logic                          sri_en_i,
    input  logic                          sri_we_i,
    input  logic [`DM_SRI_ADDR_W-1:0]     sri_addr_i,
    input  logic [63:0]                   sri_wdata_i,
    input  logic [7:0]                    sri_be_i,
    output logic [63:0]                   sri_rdata_o,
    output logic                          sri_error_o,
    // hart run control
    input  logic [`DM_NUM_HARTS-1:0]      halted_i,
    input  logic [`DM_NUM_HARTS-1:0]      running_i,
    input  logic [`DM_NUM_HARTS-1:0]      unavail_i,
    input  logic [`DM_NUM_HARTS-1:0]      resume_ack_i,
    input  logic [`DM_NUM_HARTS-1:0]      havereset_i,
    output logic [`DM_NUM_HARTS-1:0]      halt_request_o,
    output logic [`DM_NUM_HARTS-1:0]      resume_request_o
);
    dm_pkg::dmstatus_t             dmstatus;
    logic                          ctrl_we;
    logic [`DM_NUM_HARTS-1:0]      hart_sel;
    logic                          haltreq;
    logic                          resumereq;
    logic                          ackhavereset;
    logic [`DM_HARTSEL_W-1:0]      hartsel;
    logic [`DM_NUM_HARTS-1:0]      havereset_sticky;
    logic                          buf_we;
    logic [`DM_BUF_IDX_W-1:0]      buf_idx;
    logic [`DM_DMI_DATA_W-1:0]     buf_wdata;
    logic [`DM_DMI_DATA_W-1:0]     buf_rdata;

    dm_dmi_frontend u_frontend (
        .clk_i, .rstn_i, .req_valid_i, .req_addr_i, .req_data_i, .req_op_i,
        .resp_ready_i, .dmstatus_i(dmstatus), .buf_rdata_i(buf_rdata),
        .req_ready_o, .resp_valid_o, .resp_data_o, .resp_op_o,
        .ctrl_we_o(ctrl_we), .hart_sel_o(hart_sel), .haltreq_o(haltreq),
        .resumereq_o(resumereq), .ackhavereset_o(ackhavereset), .hartsel_o(hartsel),
        .buf_we_o(buf_we), .buf_idx_o(buf_idx), .buf_wdata_o(buf_wdata)
    );

    for (genvar h = 0; h < `DM_NUM_HARTS; h++) begin : g_hart
        dm_hart_ctrl u_hart_ctrl (
            .clk_i, .rstn_i, .ctrl_we_i(ctrl_we), .sel_i(hart_sel[h]),
            .haltreq_i(haltreq), .resumereq_i(resumereq),
            .ackhavereset_i(ackhavereset), .havereset_i(havereset_i[h]),
            .halt_request_o(halt_request_o[h]),
            .resume_request_o(resume_request_o[h]),
            .havereset_o(havereset_sticky[h])
        );
    end

    dm_status_collect u_status (
        .hartsel_i(hartsel), .halted_i, .running_i, .unavail_i, .resume_ack_i,
        .havereset_i(havereset_sticky), .dmstatus_o(dmstatus)
    );

    dm_progbuf_mem u_buf (
        .clk_i, .rstn_i, .dmi_we_i(buf_we), .dmi_idx_i(buf_idx), .dmi_wdata_i(buf_wdata),
        .sri_en_i, .sri_we_i, .sri_addr_i, .sri_wdata_i, .sri_be_i,
        .dmi_rdata_o(buf_rdata), .sri_rdata_o, .sri_error_o
    );

endmodule

/* test/tb_riscv_dm.sv */
/*
 * Testbench for the reduced RISC-V debug module
 * directed tests over DMI and the SRI buffer port,
 * random back-pressure on the DMI response side
 */
`timescale 1ns/100ps
`include "dm_params.svh"

module tb_riscv_dm;

    localparam int CLK_PERIOD = 100;
    localparam int HS_LIMIT   = 16;                 // cycles allowed per handshake
    // about 40 transfers of up to 8 cycles plus reset, with wide margin
    localparam int WATCHDOG_CYCLES = 2000;

    logic                          clk_i;
    logic                          rstn_i;
    logic                          req_valid_i;
    logic                          req_ready_o;
    logic [`DM_DMI_ADDR_W-1:0]     req_addr_i;
    logic [`DM_DMI_DATA_W-1:0]     req_data_i;
    dm_pkg::dmi_op_e               req_op_i;
    logic                          resp_valid_o;
    logic                          resp_ready_i;
    logic [`DM_DMI_DATA_W-1:0]     resp_data_o;
    dm_pkg::dmi_resp_e             resp_op_o;
    logic                          sri_en_i;
    logic                          sri_we_i;
    logic [`DM_SRI_ADDR_W-1:0]     sri_addr_i;
    logic [63:0]                   sri_wdata_i;
    logic [7:0]                    sri_be_i;
    logic [63:0]                   sri_rdata_o;
    logic                          sri_error_o;
    logic [`DM_NUM_HARTS-1:0]      halted_i;
    logic [`DM_NUM_HARTS-1:0]      running_i;
    logic [`DM_NUM_HARTS-1:0]      unavail_i;
    logic [`DM_NUM_HARTS-1:0]      resume_ack_i;
    logic [`DM_NUM_HARTS-1:0]      havereset_i;
    logic [`DM_NUM_HARTS-1:0]      halt_request_o;
    logic [`DM_NUM_HARTS-1:0]      resume_request_o;

    string       cur_test;
    int          err_cnt;
    int          err_start;
    int          check_cnt;
    int          test_cnt;
    int          test_fail_cnt;
    logic [31:0] buf_model [`DM_BUF_WORDS];      // expected buffer contents

    riscv_dm_top uut (.*);

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD/2) clk_i = ~clk_i;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk_i);
        $display("Timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Verification failed");
        $finish;
    end

    task automatic check_word(input string what, input logic [31:0] exp,
                              input logic [31:0] act);
        check_cnt++;
        if (act !== exp) begin
            $display("Mismatch in %s: %s expected %h actual %h", cur_test, what, exp, act);
            err_cnt++;
        end
    endtask

    task automatic check_resp(input string what, input dm_pkg::dmi_resp_e exp,
                              input dm_pkg::dmi_resp_e act);
        check_cnt++;
        if (act !== exp) begin
            $display("Mismatch in %s: %s expected %s actual %s",
                     cur_test, what, exp.name(), act.name());
            err_cnt++;
        end
    endtask

    task automatic check_harts(input string what, input logic [`DM_NUM_HARTS-1:0] exp,
                               input logic [`DM_NUM_HARTS-1:0] act);
        check_cnt++;
        if (act !== exp) begin
            $display("Mismatch in %s: %s expected %b actual %b", cur_test, what, exp, act);
            err_cnt++;
        end
    endtask

    task automatic report_error(input string msg);
        $display("Error in %s: %s", cur_test, msg);
        err_cnt++;
    endtask

    // one DMI transfer, response side stalled at random
    task automatic dmi_xfer(input logic [6:0] addr, input logic [31:0] data,
                            input dm_pkg::dmi_op_e op, output logic [31:0] rdata,
                            output dm_pkg::dmi_resp_e resp);
        int   wait_cnt;
        int   stalls;
        logic rdy;
        @(negedge clk_i);
        wait_cnt = 0;
        while (!req_ready_o && wait_cnt < HS_LIMIT) begin
            @(negedge clk_i);
            wait_cnt++;
        end
        if (!req_ready_o) report_error("DUT never became ready for a request");
        req_valid_i = 1'b1;
        req_addr_i  = addr;
        req_data_i  = data;
        req_op_i    = op;
        @(negedge clk_i);
        req_valid_i = 1'b0;
        req_op_i    = dm_pkg::DMI_NOP;
        wait_cnt = 0;
        while (!resp_valid_o && wait_cnt < HS_LIMIT) begin
            @(negedge clk_i);
            wait_cnt++;
        end
        if (!resp_valid_o) begin
            report_error("no response to the request");
            rdata = 'x;
            resp  = dm_pkg::DMI_ERROR;
        end else begin
            rdata  = resp_data_o;
            resp   = resp_op_o;
            stalls = 0;
            rdy    = 1'b0;
            while (!rdy) begin
                rdy = (stalls == 3) || ($urandom % 2 == 1);     // at most 3 stalls
                resp_ready_i = rdy;
                @(negedge clk_i);
                if (!rdy) begin
                    stalls++;
                    check_word("response data under back-pressure", rdata, resp_data_o);
                end
            end
            resp_ready_i = 1'b0;
            if (resp_valid_o) report_error("response still valid after the handshake");
        end
    endtask

    task automatic dmi_read(input logic [6:0] addr, output logic [31:0] data);
        dm_pkg::dmi_resp_e resp;
        dmi_xfer(addr, 32'h0, dm_pkg::DMI_READ, data, resp);
        check_resp("read response", dm_pkg::DMI_OK, resp);
    endtask

    task automatic dmi_write(input logic [6:0] addr, input logic [31:0] data);
        logic [31:0]       unused;
        dm_pkg::dmi_resp_e resp;
        dmi_xfer(addr, data, dm_pkg::DMI_WRITE, unused, resp);
        check_resp("write response", dm_pkg::DMI_OK, resp);
    endtask

    task automatic sri_read(input int word, output logic [63:0] data);
        @(negedge clk_i);
        sri_en_i   = 1'b1;
        sri_we_i   = 1'b0;
        sri_addr_i = `DM_SRI_ADDR_W'(word * 4);
        @(negedge clk_i);
        data     = sri_rdata_o;
        sri_en_i = 1'b0;
    endtask

    task automatic sri_write(input int word, input logic [63:0] wdata,
                             input logic [7:0] be, output logic err);
        @(negedge clk_i);
        sri_en_i    = 1'b1;
        sri_we_i    = 1'b1;
        sri_addr_i  = `DM_SRI_ADDR_W'(word * 4);
        sri_wdata_i = wdata;
        sri_be_i    = be;
        @(posedge clk_i);
        err = sri_error_o;                              // depends on tb inputs only
        @(negedge clk_i);
        sri_en_i = 1'b0;
        sri_we_i = 1'b0;
    endtask

    // dmstatus as the debug spec lays it out, one hart in the window
    function automatic logic [31:0] status_word(input int hart, input logic havereset);
        logic [31:0] w;
        w     = 32'h3;
        w[7]  = 1'b1;
        w[8]  = halted_i[hart];
        w[9]  = halted_i[hart];
        w[10] = running_i[hart];
        w[11] = running_i[hart];
        w[12] = unavail_i[hart];
        w[13] = unavail_i[hart];
        w[16] = resume_ack_i[hart];
        w[17] = resume_ack_i[hart];
        w[18] = havereset;
        w[19] = havereset;
        return w;
    endfunction

    function automatic logic [31:0] dmcontrol_word(input logic haltreq, input logic resumereq,
                                                   input logic ackhavereset,
                                                   input logic [19:0] hartsel,
                                                   input logic dmactive);
        logic [31:0] w;
        w        = '0;
        w[31]    = haltreq;
        w[30]    = resumereq;
        w[28]    = ackhavereset;
        w[25:16] = hartsel[9:0];    // hartsello
        w[15:6]  = hartsel[19:10];  // hartselhi
        w[0]     = dmactive;
        return w;
    endfunction

    task automatic begin_test(input string name);
        cur_test  = name;
        err_start = err_cnt;
        test_cnt++;
    endtask

    task automatic end_test();
        if (err_cnt == err_start) begin
            $display("test %-16s ok", cur_test);
        end else begin
            $display("test %-16s FAILED with %0d errors", cur_test, err_cnt - err_start);
            test_fail_cnt++;
        end
    endtask

    task automatic test_status();
        logic [31:0] rd;
        begin_test("status");
        dmi_read(`DM_ADDR_DMCONTROL, rd);
        check_word("DMCONTROL after reset", 32'h0, rd);
        dmi_read(`DM_ADDR_DMSTATUS, rd);
        check_word("DMSTATUS hart 0", status_word(0, 1'b0), rd);
        dmi_read(`DM_ADDR_ABSTRACTCS, rd);
        check_word("ABSTRACTCS", (32'(`DM_PROG_SIZE) << 24) | 32'(`DM_DATA_SIZE), rd);
        end_test();
    endtask

    task automatic test_hartsel();
        logic [31:0] rd;
        begin_test("hartsel_halt");
        dmi_write(`DM_ADDR_DMCONTROL, dmcontrol_word(1'b1, 1'b0, 1'b0, 20'd2, 1'b1));
        check_harts("halt_request_o", 4'b0100, halt_request_o);
        // hartsel 7 does not exist, so the write lands on hart 2
        dmi_write(`DM_ADDR_DMCONTROL, dmcontrol_word(1'b0, 1'b0, 1'b0, 20'd7, 1'b1));
        dmi_read(`DM_ADDR_DMCONTROL, rd);
        check_word("DMCONTROL after hartsel 7", dmcontrol_word(0, 0, 0, 20'd2, 1'b1), rd);
        check_harts("halt_request_o after hartsel 7", 4'b0000, halt_request_o);
        end_test();
    endtask

    task automatic test_resume();
        begin_test("resume");
        dmi_write(`DM_ADDR_DMCONTROL, dmcontrol_word(1'b1, 1'b1, 1'b0, 20'd2, 1'b1));
        check_harts("resume_request_o with haltreq", 4'b0000, resume_request_o);
        dmi_write(`DM_ADDR_DMCONTROL, dmcontrol_word(1'b0, 1'b0, 1'b0, 20'd2, 1'b1));
        check_harts("halt_request_o cleared", 4'b0000, halt_request_o);
        dmi_write(`DM_ADDR_DMCONTROL, dmcontrol_word(1'b0, 1'b1, 1'b0, 20'd2, 1'b1));
        check_harts("resume_request_o", 4'b0100, resume_request_o);
        end_test();
    endtask

    task automatic test_havereset();
        logic [31:0] rd;
        begin_test("havereset");
        dmi_write(`DM_ADDR_DMCONTROL, dmcontrol_word(1'b0, 1'b0, 1'b0, 20'd1, 1'b1));
        @(negedge clk_i);
        havereset_i[1] = 1'b1;
        @(negedge clk_i);
        havereset_i[1] = 1'b0;                          // sticky from here on
        dmi_read(`DM_ADDR_DMSTATUS, rd);
        check_word("DMSTATUS after havereset", status_word(1, 1'b1), rd);
        dmi_write(`DM_ADDR_DMCONTROL, dmcontrol_word(1'b0, 1'b0, 1'b1, 20'd1, 1'b1));
        dmi_read(`DM_ADDR_DMSTATUS, rd);
        check_word("DMSTATUS after ack", status_word(1, 1'b0), rd);
        end_test();
    endtask

    task automatic test_buffer();
        logic [31:0] rd;
        logic [63:0] pair;
        begin_test("buffer");
        for (int i = 0; i < `DM_BUF_WORDS; i++) begin
            buf_model[i] = $urandom;
        end
        for (int i = 0; i < `DM_PROG_SIZE; i++) begin
            dmi_write(`DM_ADDR_PROGBUF0 + i, buf_model[i]);
        end
        for (int i = 0; i < `DM_DATA_SIZE; i++) begin
            dmi_write(`DM_ADDR_DATA0 + i, buf_model[`DM_PROG_SIZE + i]);
        end
        for (int i = 0; i < `DM_PROG_SIZE; i++) begin
            dmi_read(`DM_ADDR_PROGBUF0 + i, rd);
            check_word($sformatf("PROGBUF%0d", i), buf_model[i], rd);
        end
        for (int i = 0; i < `DM_DATA_SIZE; i++) begin
            dmi_read(`DM_ADDR_DATA0 + i, rd);
            check_word($sformatf("DATA%0d", i), buf_model[`DM_PROG_SIZE + i], rd);
        end
        sri_read(0, pair);
        check_word("SRI word 0 low", buf_model[0], pair[31:0]);
        check_word("SRI word 0 high", buf_model[1], pair[63:32]);
        sri_read(4, pair);
        check_word("SRI word 4 low", buf_model[4], pair[31:0]);
        check_word("SRI word 4 high", buf_model[5], pair[63:32]);
        sri_read(6, pair);
        check_word("SRI word 6 low", `DM_EBREAK, pair[31:0]);
        check_word("SRI word 6 high", `DM_EBREAK, pair[63:32]);
        end_test();
    endtask

    task automatic test_sri_write();
        logic [31:0]       rd;
        logic              err;
        dm_pkg::dmi_resp_e resp;
        begin_test("sri_write");
        sri_write(5, 64'h1122_3344_5566_7788, 8'h0F, err);
        check_word("sri_error_o in range", 32'h0, {31'b0, err});
        buf_model[5] = 32'h5566_7788;
        dmi_read(`DM_ADDR_DATA0 + 1, rd);
        check_word("DATA1 after SRI write", buf_model[5], rd);
        dmi_read(`DM_ADDR_DATA0, rd);
        check_word("DATA0 untouched", buf_model[4], rd);
        sri_write(7, 64'hffff_ffff_ffff_ffff, 8'hFF, err);
        check_word("sri_error_o out of range", 32'h1, {31'b0, err});
        dmi_xfer(`DM_ADDR_SBCS, 32'h0, dm_pkg::DMI_WRITE, rd, resp);
        check_resp("SBCS write response", dm_pkg::DMI_ERROR, resp);
        end_test();
    endtask

    initial begin
        void'($urandom(32'hb5d56a0b));
        err_cnt       = 0;
        check_cnt     = 0;
        test_cnt      = 0;
        test_fail_cnt = 0;
        rstn_i        = 1'b0;
        req_valid_i   = 1'b0;
        req_addr_i    = '0;
        req_data_i    = '0;
        req_op_i      = dm_pkg::DMI_NOP;
        resp_ready_i  = 1'b0;
        sri_en_i      = 1'b0;
        sri_we_i      = 1'b0;
        sri_addr_i    = '0;
        sri_wdata_i   = '0;
        sri_be_i      = '0;
        halted_i      = 4'b0101;
        running_i     = 4'b1010;
        unavail_i     = 4'b1001;
        resume_ack_i  = 4'b0110;
        havereset_i   = '0;
        repeat (8) @(negedge clk_i);
        rstn_i = 1'b1;

        test_status();
        test_hartsel();
        test_resume();
        test_havereset();
        test_buffer();
        test_sri_write();

        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 test_cnt, test_fail_cnt, check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

/* verilog.f */
+incdir+hw
hw/dm_pkg.sv
hw/dm_dmi_frontend.sv
hw/dm_hart_ctrl.sv
hw/dm_status_collect.sv
hw/dm_progbuf_mem.sv
hw/riscv_dm_top.sv
test/tb_riscv_dm.sv

/* Bender.yml */
package:
  name: riscv_dm

export_include_dirs:
  - hw

sources:
  - include_dirs:
      - hw
    files:
      - hw/dm_pkg.sv
      - hw/dm_dmi_frontend.sv
      - hw/dm_hart_ctrl.sv
      - hw/dm_status_collect.sv
      - hw/dm_progbuf_mem.sv
      - hw/riscv_dm_top.sv
  - target: simulation
    include_dirs:
      - hw
    files:
      - test/tb_riscv_dm.sv
